// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_lite -f rv_lite.f -o sim_rv_lite

if ./obj_dir/sim_rv_lite | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== rv_lite.f ====
rv_lite_pkg.sv
rv_lite_decode.sv
rv_lite_regfile.sv
rv_lite_execute.sv
rv_lite_result.sv
rv_lite_core.sv
tb_rv_lite.sv

// ==== rv_lite_core.sv ====
module rv_lite_core (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [rv_lite_pkg::xlen-1:0]       inst,
  output logic [rv_lite_pkg::xlen-1:0]       pc,
  output logic                               wb_cyc,
  output logic                               wb_stb,
  output logic                               wb_we,
  output logic [rv_lite_pkg::xlen-1:0]       wb_adr,
  output logic [rv_lite_pkg::xlen-1:0]       wb_dat_w,
  output logic [rv_lite_pkg::sel_w-1:0]      wb_sel,
  input  logic [rv_lite_pkg::xlen-1:0]       wb_dat_r,
  input  logic                               wb_ack
);

  logic [rv_lite_pkg::reg_addr_w-1:0] rs1;
  logic [rv_lite_pkg::reg_addr_w-1:0] rs2;
  logic [rv_lite_pkg::reg_addr_w-1:0] rd;
  logic [rv_lite_pkg::funct3_w-1:0]   funct3;
  logic [rv_lite_pkg::xlen-1:0]       imm;
  logic                               pc_base;
  logic                               jump;
  logic                               jump_reg;
  logic                               reg_we;
  logic                               mem_rd;
  logic                               mem_wr;
  logic [rv_lite_pkg::xlen-1:0]       rs1_data;
  logic [rv_lite_pkg::xlen-1:0]       rs2_data;
  logic [rv_lite_pkg::xlen-1:0]       sum;
  logic [rv_lite_pkg::xlen-1:0]       link;
  logic                               mem_wait;
  logic                               rd_we;
  logic [rv_lite_pkg::xlen-1:0]       rd_data;

  rv_lite_decode decode_inst (
    .inst     (inst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .funct3   (funct3),
    .imm      (imm),
    .pc_base  (pc_base),
    .jump     (jump),
    .jump_reg (jump_reg),
    .reg_we   (reg_we),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr)
  );

  rv_lite_regfile regfile_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .we       (rd_we),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_lite_execute execute_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_data (rs1_data),
    .imm      (imm),
    .pc_base  (pc_base),
    .jump     (jump),
    .jump_reg (jump_reg),
    .mem_wait (mem_wait),
    .pc       (pc),
    .sum      (sum),
    .link     (link)
  );

  // data bus master and write-back
  rv_lite_result result_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .sum      (sum),
    .link     (link),
    .rs2_data (rs2_data),
    .funct3   (funct3),
    .jump     (jump),
    .reg_we   (reg_we),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .mem_wait (mem_wait),
    .rd_we    (rd_we),
    .rd_data  (rd_data)
  );

endmodule

// ==== rv_lite_decode.sv ====
module rv_lite_decode (
  input  rv_lite_pkg::inst_u                    inst,
  output logic [rv_lite_pkg::reg_addr_w-1:0]    rs1,
  output logic [rv_lite_pkg::reg_addr_w-1:0]    rs2,
  output logic [rv_lite_pkg::reg_addr_w-1:0]    rd,
  output logic [rv_lite_pkg::funct3_w-1:0]      funct3,
  output logic [rv_lite_pkg::xlen-1:0]          imm,
  output logic                                  pc_base,
  output logic                                  jump,
  output logic                                  jump_reg,
  output logic                                  reg_we,
  output logic                                  mem_rd,
  output logic                                  mem_wr
);

  logic [rv_lite_pkg::xlen-1:0]     word;
  logic [rv_lite_pkg::opcode_w-1:0] opcode;
  logic [rv_lite_pkg::xlen-1:0]     imm_i;
  logic [rv_lite_pkg::xlen-1:0]     imm_s;
  logic [rv_lite_pkg::xlen-1:0]     imm_u;
  logic [rv_lite_pkg::xlen-1:0]     imm_j;

  assign word   = inst;  // raw view for the U and J fields
  assign opcode = inst.i.opcode;
  assign rs2    = inst.s.rs2;
  assign rd     = inst.i.rd;
  assign funct3 = inst.i.funct3;

  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {word[31:12], 12'h000};  // already shifted into place
  assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

  always_comb begin
    rs1      = inst.i.rs1;
    imm      = imm_i;
    pc_base  = 1'b0;
    jump     = 1'b0;
    jump_reg = 1'b0;
    reg_we   = 1'b0;
    mem_rd   = 1'b0;
    mem_wr   = 1'b0;
    case (opcode)
      rv_lite_pkg::op_imm: begin
        reg_we = (inst.i.funct3 == rv_lite_pkg::f3_addi);
      end
      rv_lite_pkg::op_lui: begin
        rs1    = '0;  // x0 + imm
        imm    = imm_u;
        reg_we = 1'b1;
      end
      rv_lite_pkg::op_auipc: begin
        imm     = imm_u;
        pc_base = 1'b1;
        reg_we  = 1'b1;
      end
      rv_lite_pkg::op_jal: begin
        imm     = imm_j;
        pc_base = 1'b1;
        jump    = 1'b1;
        reg_we  = 1'b1;
      end
      rv_lite_pkg::op_jalr: begin
        jump     = 1'b1;
        jump_reg = 1'b1;
        reg_we   = 1'b1;
      end
      rv_lite_pkg::op_load: begin
        case (inst.i.funct3)
          rv_lite_pkg::f3_b, rv_lite_pkg::f3_h, rv_lite_pkg::f3_w,
          rv_lite_pkg::f3_bu, rv_lite_pkg::f3_hu: begin
            mem_rd = 1'b1;
            reg_we = 1'b1;
          end
          default: ;  // unknown size, no-op
        endcase
      end
      rv_lite_pkg::op_store: begin
        imm    = imm_s;
        mem_wr = (inst.s.funct3 == rv_lite_pkg::f3_b) ||
                 (inst.s.funct3 == rv_lite_pkg::f3_h) ||
                 (inst.s.funct3 == rv_lite_pkg::f3_w);
      end
      default: ;  // dropped opcodes fall through as no-ops
    endcase
  end

endmodule

// ==== rv_lite_execute.sv ====
module rv_lite_execute (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [rv_lite_pkg::xlen-1:0] rs1_data,
  input  logic [rv_lite_pkg::xlen-1:0] imm,
  input  logic                         pc_base,
  input  logic                         jump,
  input  logic                         jump_reg,
  input  logic                         mem_wait,
  output logic [rv_lite_pkg::xlen-1:0] pc,
  output logic [rv_lite_pkg::xlen-1:0] sum,
  output logic [rv_lite_pkg::xlen-1:0] link
);

  logic [rv_lite_pkg::xlen-1:0] base;
  logic [rv_lite_pkg::xlen-1:0] target;
  logic [rv_lite_pkg::xlen-1:0] next_pc;

  // one adder for addresses, results and jump targets
  assign base = pc_base ? pc : rs1_data;
  assign sum  = base + imm;
  assign link = pc + 32'd4;

  assign target  = jump_reg ? {sum[rv_lite_pkg::xlen-1:1], 1'b0} : sum;  // jalr drops bit 0
  assign next_pc = jump ? target : link;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= rv_lite_pkg::reset_pc;
    end else if (!mem_wait) begin
      pc <= next_pc;
    end
  end

  // jump targets come from the register file and the decoded immediate
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// ==== rv_lite_patterns.mem ====
// header at 00: program words, store records, initial data words
// program at 10, data ram at 50, store records at 60 as address data select
@00
00000025 00000013 00000002
@10
100000b7 12300113 ffb10193 00001217  // lui x1, addi x2, addi x3, auipc x4
0220a023 0230a223 0240a423 0210a623  // sw x2, x3, x4, x1
00c002ef ffffffff ffffffff 0250a823  // jal x5 over two slots, sw x5
01928367 ffffffff ffffffff 0260aa23  // jalr x6 to 3c, sw x6
04208023 042080a3 04208123 042081a3  // sb at offsets 0 to 3
04409223 04409323                    // sh at offsets 0 and 2
00108383 0470a423 0020c403 0480a623  // lb, sw, lbu, sw
00009483 0490a823 0060d503 04a0aa23  // lh, sw, lhu, sw
0040a583 04b0ac23 00609603 04c0ae23  // lw, sw, lh, sw
00210133 0620a023 0000006f           // add as no-op, sw x2, park
@50
12f48a7c c3a55e96
@60
10000020 00000123 0000000f
10000024 0000011e 0000000f
10000028 8000100c 0000000f
1000002c 10000000 0000000f
10000030 80000024 0000000f  // jal link
10000034 80000034 0000000f  // jalr link
10000040 23232323 00000001
10000040 23232323 00000002
10000040 23232323 00000004
10000040 23232323 00000008
10000044 100c100c 00000003
10000044 100c100c 0000000c
10000048 ffffff8a 0000000f  // lb
1000004c 000000f4 0000000f  // lbu
10000050 ffff8a7c 0000000f  // lh
10000054 0000c3a5 0000000f  // lhu
10000058 c3a55e96 0000000f  // lw
1000005c ffffc3a5 0000000f  // lh upper half
10000060 00000123 0000000f  // x2 untouched by add

// ==== rv_lite_pkg.sv ====
package rv_lite_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int opcode_w   = 7;
  localparam int funct3_w   = 3;
  localparam int sel_w      = 4;  // one bit per byte lane

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes, only the supported ones
  localparam logic [opcode_w-1:0] op_imm   = 7'b001_0011;
  localparam logic [opcode_w-1:0] op_lui   = 7'b011_0111;
  localparam logic [opcode_w-1:0] op_auipc = 7'b001_0111;
  localparam logic [opcode_w-1:0] op_jal   = 7'b110_1111;
  localparam logic [opcode_w-1:0] op_jalr  = 7'b110_0111;
  localparam logic [opcode_w-1:0] op_load  = 7'b000_0011;
  localparam logic [opcode_w-1:0] op_store = 7'b010_0011;

  // access size codes, stores use b/h/w only
  localparam logic [funct3_w-1:0] f3_b  = 3'b000;
  localparam logic [funct3_w-1:0] f3_h  = 3'b001;
  localparam logic [funct3_w-1:0] f3_w  = 3'b010;
  localparam logic [funct3_w-1:0] f3_bu = 3'b100;
  localparam logic [funct3_w-1:0] f3_hu = 3'b101;

  localparam logic [funct3_w-1:0] f3_addi = 3'b000;  // the only op-imm kept

  // one instruction word, read as I-type or as S-type
  typedef union packed {
    struct packed {
      logic [11:0]           imm;
      logic [reg_addr_w-1:0] rs1;
      logic [funct3_w-1:0]   funct3;
      logic [reg_addr_w-1:0] rd;
      logic [opcode_w-1:0]   opcode;
    } i;
    struct packed {
      logic [6:0]            imm_hi;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [funct3_w-1:0]   funct3;
      logic [4:0]            imm_lo;
      logic [opcode_w-1:0]   opcode;
    } s;
  } inst_u;

endpackage

// ==== rv_lite_regfile.sv ====
module rv_lite_regfile (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [rv_lite_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_lite_pkg::reg_addr_w-1:0] rs2,
  input  logic                               we,
  input  logic [rv_lite_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_lite_pkg::xlen-1:0]       rd_data,
  output logic [rv_lite_pkg::xlen-1:0]       rs1_data,
  output logic [rv_lite_pkg::xlen-1:0]       rs2_data
);

  localparam int depth = 1 << rv_lite_pkg::reg_addr_w;

  logic [rv_lite_pkg::xlen-1:0] regs [depth];

  // x0 is cleared here and never written afterwards
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];  // async read
  assign rs2_data = regs[rs2];

endmodule

// ==== rv_lite_result.sv ====
module rv_lite_result (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [rv_lite_pkg::xlen-1:0]       sum,
  input  logic [rv_lite_pkg::xlen-1:0]       link,
  input  logic [rv_lite_pkg::xlen-1:0]       rs2_data,
  input  logic [rv_lite_pkg::funct3_w-1:0]   funct3,
  input  logic                               jump,
  input  logic                               reg_we,
  input  logic                               mem_rd,
  input  logic                               mem_wr,
  input  logic [rv_lite_pkg::xlen-1:0]       wb_dat_r,
  input  logic                               wb_ack,
  output logic                               wb_cyc,
  output logic                               wb_stb,
  output logic                               wb_we,
  output logic [rv_lite_pkg::xlen-1:0]       wb_adr,
  output logic [rv_lite_pkg::xlen-1:0]       wb_dat_w,
  output logic [rv_lite_pkg::sel_w-1:0]      wb_sel,
  output logic                               mem_wait,
  output logic                               rd_we,
  output logic [rv_lite_pkg::xlen-1:0]       rd_data
);

  logic                         run;
  logic                         mem_req;
  logic                         misaligned;
  logic [rv_lite_pkg::xlen-1:0] lane;
  logic [rv_lite_pkg::xlen-1:0] load_data;

  // first cycle after reset release issues nothing
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  assign mem_req  = run && (mem_rd || mem_wr);
  assign wb_cyc   = mem_req;
  assign wb_stb   = mem_req;
  assign wb_we    = mem_req && mem_wr;
  assign wb_adr   = {sum[rv_lite_pkg::xlen-1:2], 2'b00};
  assign mem_wait = !run || (mem_req && !wb_ack);  // pc holds while high

  // store lanes and byte selects by access size
  always_comb begin
    case (funct3)
      rv_lite_pkg::f3_b, rv_lite_pkg::f3_bu: begin
        wb_dat_w   = {4{rs2_data[7:0]}};
        wb_sel     = 4'b0001 << sum[1:0];
        misaligned = 1'b0;
      end
      rv_lite_pkg::f3_h, rv_lite_pkg::f3_hu: begin
        wb_dat_w   = {2{rs2_data[15:0]}};
        wb_sel     = sum[1] ? 4'b1100 : 4'b0011;
        misaligned = sum[0];
      end
      default: begin
        wb_dat_w   = rs2_data;
        wb_sel     = 4'b1111;
        misaligned = |sum[1:0];
      end
    endcase
  end

  assign lane = wb_dat_r >> {sum[1:0], 3'b000};  // addressed lane down to bit 0

  always_comb begin
    case (funct3)
      rv_lite_pkg::f3_b:  load_data = {{24{lane[7]}}, lane[7:0]};
      rv_lite_pkg::f3_h:  load_data = {{16{lane[15]}}, lane[15:0]};
      rv_lite_pkg::f3_bu: load_data = {24'h00_0000, lane[7:0]};
      rv_lite_pkg::f3_hu: load_data = {16'h0000, lane[15:0]};
      default:            load_data = wb_dat_r;
    endcase
  end

  assign rd_we   = run && reg_we && (!mem_rd || wb_ack);  // loads wait for ack
  assign rd_data = mem_rd ? load_data : (jump ? link : sum);

  // pc and the fetched word must stay put across wait states
  a_req_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_sel) &&
                             $stable(wb_dat_w) && $stable(wb_we)
  ) else $error("bus request changed before ack");

  a_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    wb_stb |-> !misaligned
  ) else $error("misaligned access at %h", sum);

endmodule

// ==== tb_rv_lite.sv ====
module tb_rv_lite;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          pat_depth      = 256;
  localparam int          ram_depth      = 64;
  localparam int          timeout_margin = 100;
  localparam int          data_base      = 'h50;
  localparam logic [7:0]  prog_base      = 8'h10;
  localparam logic [7:0]  rec_base       = 8'h60;  // address, data, select per store
  localparam logic [31:0] poison         = 32'hffff_ffff;  // slots a jump must skip

  logic        clk;
  logic        arst_n   = 1'b0;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r = 32'h0;
  logic        wb_ack   = 1'b0;

  logic [31:0] pat [pat_depth];
  logic [31:0] ram [ram_depth];
  logic [31:0] prog_len  = 32'h0;
  int          store_cnt = 0;
  int          store_idx = 0;
  int          limit;
  int          cycles;
  logic        done      = 1'b0;
  logic [31:0] lfsr      = 32'h25d9_0776;
  logic        busy      = 1'b0;
  logic [1:0]  wait_left = 2'd0;
  logic [31:0] rom_idx;
  logic [7:0]  rom_slot;

  // previous cycle as seen by the monitor
  logic        first_cycle = 1'b0;
  logic        last_valid  = 1'b0;
  logic        last_hold   = 1'b0;
  logic        last_req    = 1'b0;
  logic        last_jump   = 1'b0;
  logic [31:0] last_pc     = 32'h0;
  logic [31:0] last_adr    = 32'h0;
  logic [31:0] last_dat_w  = 32'h0;
  logic [3:0]  last_sel    = 4'h0;
  logic        last_we     = 1'b0;

  rv_lite_core rv_lite_core_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .inst     (inst),
    .pc       (pc),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  // instruction rom, same-cycle answer to pc
  assign rom_idx  = (pc - rv_lite_pkg::reset_pc) >> 2;
  assign rom_slot = prog_base + rom_idx[7:0];
  assign inst     = (rom_idx < prog_len) ? pat[rom_slot] : poison;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic draw_delay(output logic [1:0] d);
    lfsr = lfsr_next(lfsr);
    d[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    d[1] = lfsr[0];
  endtask

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic match_store();
    logic [7:0] base;
    if (store_idx >= store_cnt) begin
      fail_run("bus write seen after the last expected store");
    end else begin
      base = rec_base + 8'(3 * store_idx);
      check_value("wb_adr", wb_adr, pat[base]);
      check_value("wb_dat_w", wb_dat_w, pat[base + 8'd1]);
      check_value("wb_sel", {28'h0, wb_sel}, pat[base + 8'd2]);
      store_idx = store_idx + 1;
      if (store_idx == store_cnt) begin
        done <= 1'b1;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // wishbone slave, registered ack after a random number of wait cycles
  always @(posedge clk) begin
    logic [1:0] new_wait;
    if (!arst_n) begin
      wb_ack <= 1'b0;
      busy   <= 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;  // transfer completes on this edge
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        draw_delay(new_wait);
        wait_left <= new_wait;
        busy      <= 1'b1;
      end else if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        busy     <= 1'b0;
        wb_ack   <= 1'b1;
        wb_dat_r <= ram[wb_adr[7:2]];
        if (wb_we) begin
          match_store();
          for (int b = 0; b < 4; b++) begin
            if (wb_sel[b]) begin
              ram[wb_adr[7:2]][8*b +: 8] = wb_dat_w[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // fetch order, pc hold and bus stability
  always @(posedge clk) begin
    if (!arst_n) begin
      if ((wb_cyc === 1'b1) || (wb_stb === 1'b1)) begin
        fail_run("bus cycle started while reset was asserted");
      end
      first_cycle <= 1'b1;
      last_valid  <= 1'b0;
    end else begin
      if (inst === poison) begin
        fail_run("fetched an instruction that a jump should have skipped");
      end
      if (wb_stb !== wb_cyc) begin
        fail_run("wb_stb and wb_cyc did not rise and fall together");
      end
      if (first_cycle) begin
        check_value("pc", pc, rv_lite_pkg::reset_pc);
        check_value("wb_cyc", {31'h0, wb_cyc}, 32'h0);
      end
      if (last_valid) begin
        if (last_hold) begin
          check_value("pc", pc, last_pc);
        end else if (!last_jump) begin
          check_value("pc", pc, last_pc + 32'd4);
        end
        if (last_req) begin
          check_value("wb_cyc", {31'h0, wb_cyc}, 32'h1);
          check_value("wb_adr", wb_adr, last_adr);
          check_value("wb_dat_w", wb_dat_w, last_dat_w);
          check_value("wb_sel", {28'h0, wb_sel}, {28'h0, last_sel});
          check_value("wb_we", {31'h0, wb_we}, {31'h0, last_we});
        end
      end
      last_valid  <= 1'b1;
      last_hold   <= first_cycle || (wb_cyc && !wb_ack);
      last_req    <= wb_cyc && !wb_ack;
      last_jump   <= (inst[6:0] == 7'h6f) || (inst[6:0] == 7'h67);  // jal, jalr
      last_pc     <= pc;
      last_adr    <= wb_adr;
      last_dat_w  <= wb_dat_w;
      last_sel    <= wb_sel;
      last_we     <= wb_we;
      first_cycle <= 1'b0;
    end
  end

  initial begin
    for (int i = 0; i < pat_depth; i++) begin
      pat[i] = 32'h0;
    end
    $readmemh("rv_lite_patterns.mem", pat);
    prog_len  = pat[0];
    store_cnt = int'(pat[1]);
    for (int i = 0; i < ram_depth; i++) begin
      ram[i] = 32'hbeef_0000 | 32'(i);  // fill follows the word address
    end
    for (int i = 0; i < int'(pat[2]); i++) begin
      ram[i] = pat[data_base + i];
    end
    if (prog_len == 32'h0 || store_cnt == 0) begin
      fail_run("pattern file is missing or its header is empty");
    end
    limit  = int'(prog_len) * 5 + timeout_margin;
    cycles = 0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    while (!done && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (done) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                         cycles, store_idx, store_cnt));
    end
  end

endmodule
